//--- lsuTop.f
src/lsuPkg.sv
src/lsuIssue.sv
src/cacheArrays.sv
src/lsuTagCheck.sv
src/lsuComplete.sv
src/lsuTop.sv
verification/lsuTop_tb.sv

//--- run.sh
#!/bin/sh
# builds the load/store unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f lsuTop.f --top-module lsuTop_tb -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench passed" sim.log; then
    exit 0
fi
exit 1

//--- src/cacheArrays.sv
// tag table, valid bits and data array with registered read and a shared write port
`timescale 1ns/10ps
`default_nettype none

module cacheArrays (
    input wire clk,
    input wire rst,
    input wire lsuPkg::SetIdx readIndex,
    output lsuPkg::WayTags tagsOut,
    output logic [lsuPkg::NUM_WAYS-1:0] validsOut,
    output lsuPkg::WayLines lineOut,
    input wire lsuPkg::CacheFill fill,
    input wire storeWrite,
    input wire lsuPkg::WayIdx storeWay,
    input wire [lsuPkg::ADDR_W-1:0] storeAddr,
    input wire lsuPkg::Word storeData,
    input wire [3:0] storeMask
);
    import lsuPkg::*;

    WayTags tagMem [NUM_SETS];
    WayLines dataMem [NUM_SETS];
    logic [NUM_WAYS-1:0] validBits [NUM_SETS];

    SetIdx fillSet;
    SetIdx storeSet;
    logic [OFFSET_W-3:0] storeWordSel;

    assign fillSet = fill.addr[OFFSET_W +: INDEX_W];
    assign storeSet = storeAddr[OFFSET_W +: INDEX_W];
    assign storeWordSel = storeAddr[OFFSET_W-1:2];

    // valid bits and their registered read
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                validBits[s] <= '0;
            end
            validsOut <= '0;
        end else begin
            validsOut <= validBits[readIndex];
            if (fill.valid) begin
                validBits[fillSet][fill.way] <= 1'b1;
            end
        end
    end

    // reads see the contents from before a same-cycle write
    always_ff @(posedge clk) begin
        tagsOut <= tagMem[readIndex];
        lineOut <= dataMem[readIndex];
        if (fill.valid) begin
            tagMem[fillSet][fill.way] <= fill.addr[ADDR_W-1 -: TAG_W];
            dataMem[fillSet][fill.way] <= fill.line;
        end else if (storeWrite) begin
            // byte lanes of one word
            for (int b = 0; b < 4; b++) begin
                if (storeMask[b]) begin
                    dataMem[storeSet][storeWay][storeWordSel][8*b +: 8] <= storeData[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/lsuComplete.sv
// third pipeline stage with load results, acks, store writes, miss reports and the victim counter
`timescale 1ns/10ps
`default_nettype none

module lsuComplete (
    input wire clk,
    input wire rst,
    input wire lsuPkg::TagCheckResult checked,
    input wire fillValid,
    input wire missReady,
    output lsuPkg::LoadResult loadResult,
    output lsuPkg::LoadAck loadAck,
    output lsuPkg::StoreAck storeAck,
    output lsuPkg::CacheMiss miss,
    output logic storeWrite,
    output lsuPkg::WayIdx storeWay,
    output logic [lsuPkg::ADDR_W-1:0] storeAddr,
    output lsuPkg::Word storeData,
    output logic [3:0] storeMask,
    output lsuPkg::WayIdx victimWay
);
    import lsuPkg::*;

    MemOp op;
    logic isLoadOp;
    logic isStoreOp;
    WayIdx victimCount;
    WayIdx victimNext;

    assign op = checked.op;
    assign isLoadOp = op.valid && !op.isStore;
    assign isStoreOp = op.valid && op.isStore;

    // a load that misses is nacked and replayed by the requester
    always_comb begin
        loadResult.valid = isLoadOp && checked.hit;
        loadResult.id = op.id;
        loadResult.data = checked.loadWord;
        loadAck.valid = isLoadOp && !checked.hit;
        loadAck.id = op.id;
        loadAck.addr = op.addr;
    end

    // the fill owns the write port in its cycle
    assign storeWrite = isStoreOp && checked.hit && !fillValid;
    assign storeWay = checked.hitWay;
    assign storeAddr = op.addr;
    assign storeData = op.data;
    assign storeMask = op.wmask;

    always_comb begin
        storeAck.valid = isStoreOp;
        storeAck.id = op.id;
        storeAck.fail = !checked.hit || fillValid;
    end

    always_comb begin
        miss.valid = op.valid && !checked.hit;
        miss.mtype = checked.victimValid ? missRegular : missNoEvict;
        miss.missAddr = op.addr;
        miss.evictAddr = {checked.victimTag, op.addr[OFFSET_W +: INDEX_W], {OFFSET_W{1'b0}}};
        miss.way = victimCount;
    end

    // only a miss the refill agent takes moves the counter
    assign victimNext = victimCount + WayIdx'(miss.valid && missReady);

    // stage 1 arrives here next cycle and sees the counter's next value
    assign victimWay = victimNext;

    always_ff @(posedge clk) begin
        if (rst) begin
            victimCount <= '0;
        end else begin
            victimCount <= victimNext;
        end
    end

endmodule

`default_nettype wire

//--- src/lsuIssue.sv
// first pipeline stage with port arbitration, stall generation and the issue register
`timescale 1ns/10ps
`default_nettype none

module lsuIssue (
    input wire clk,
    input wire rst,
    input wire lsuPkg::LoadReq loadReq,
    input wire lsuPkg::StoreReq storeReq,
    input wire fillValid,
    output logic loadStall,
    output logic storeStall,
    output lsuPkg::SetIdx readIndex,
    output lsuPkg::MemOp issued
);
    import lsuPkg::*;

    // bit 0 marks a store in stage 1 and bit 1 a store in stage 2
    logic [1:0] storeStage;
    logic loadAccept;
    logic storeAccept;
    MemOp chosen;

    // a store in flight has not written the cache yet, so loads wait for it
    assign loadStall = fillValid || (|storeStage);
    // loads win the port
    assign storeStall = fillValid || loadReq.valid;

    assign loadAccept = loadReq.valid && !loadStall;
    assign storeAccept = storeReq.valid && !storeStall;

    always_comb begin
        chosen.valid = loadAccept || storeAccept;
        chosen.isStore = !loadAccept;
        chosen.data = storeReq.data;
        chosen.wmask = storeReq.wmask;
        if (loadAccept) begin
            chosen.addr = loadReq.addr;
            chosen.id = loadReq.id;
        end else begin
            chosen.addr = storeReq.addr;
            chosen.id = storeReq.id;
        end
    end

    // arrays register this index so their output lines up with stage 1
    assign readIndex = chosen.addr[OFFSET_W +: INDEX_W];

    always_ff @(posedge clk) begin
        issued <= chosen;
        if (rst) begin
            issued.valid <= 1'b0;
            storeStage <= '0;
        end else begin
            storeStage <= {storeStage[0], storeAccept};
        end
    end

endmodule

`default_nettype wire

//--- src/lsuPkg.sv
// cache geometry, shared types, request/result/miss structs and the miss type enum
`default_nettype none

package lsuPkg;

    // geometry
    localparam int ADDR_W = 32;
    localparam int LINE_BYTES = 16;
    localparam int OFFSET_W = $clog2(LINE_BYTES);
    localparam int WORDS_PER_LINE = LINE_BYTES / 4;
    localparam int NUM_SETS = 16;
    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int NUM_WAYS = 4;
    localparam int WAY_W = $clog2(NUM_WAYS);
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [5:0] SeqId;
    typedef logic [31:0] Word;
    typedef logic [TAG_W-1:0] Tag;
    typedef logic [INDEX_W-1:0] SetIdx;
    typedef logic [WAY_W-1:0] WayIdx;
    typedef Word [WORDS_PER_LINE-1:0] LineData;
    typedef Tag [NUM_WAYS-1:0] WayTags;
    typedef LineData [NUM_WAYS-1:0] WayLines;

    // missRegular evicts a valid victim and missNoEvict fills an empty way
    typedef enum logic {
        missRegular,
        missNoEvict
    } MissType;

    typedef struct packed {
        logic valid;
        logic [ADDR_W-1:0] addr;
        SeqId id;
    } LoadReq;

    typedef struct packed {
        logic valid;
        logic [ADDR_W-1:0] addr;
        Word data;
        logic [3:0] wmask;
        SeqId id;
    } StoreReq;

    // addr is line aligned
    typedef struct packed {
        logic valid;
        logic [ADDR_W-1:0] addr;
        LineData line;
        WayIdx way;
    } CacheFill;

    typedef struct packed {
        logic valid;
        MissType mtype;
        logic [ADDR_W-1:0] missAddr;
        logic [ADDR_W-1:0] evictAddr;
        WayIdx way;
    } CacheMiss;

    typedef struct packed {
        logic valid;
        SeqId id;
        Word data;
    } LoadResult;

    // negative ack that tells the requester to replay the load
    typedef struct packed {
        logic valid;
        SeqId id;
        logic [ADDR_W-1:0] addr;
    } LoadAck;

    typedef struct packed {
        logic valid;
        SeqId id;
        logic fail;
    } StoreAck;

    typedef struct packed {
        logic valid;
        logic isStore;
        logic [ADDR_W-1:0] addr;
        Word data;
        logic [3:0] wmask;
        SeqId id;
    } MemOp;

    typedef struct packed {
        MemOp op;
        logic hit;
        WayIdx hitWay;
        Word loadWord;
        logic victimValid;
        Tag victimTag;
    } TagCheckResult;

endpackage

`default_nettype wire

//--- src/lsuTagCheck.sv
// second pipeline stage with tag compare, hit way encoding, word select and victim lookup
`timescale 1ns/10ps
`default_nettype none

module lsuTagCheck (
    input wire clk,
    input wire rst,
    input wire lsuPkg::MemOp op,
    input wire lsuPkg::WayTags tags,
    input wire [lsuPkg::NUM_WAYS-1:0] valids,
    input wire lsuPkg::WayLines line,
    input wire lsuPkg::WayIdx victimWay,
    output lsuPkg::TagCheckResult result
);
    import lsuPkg::*;

    Tag opTag;
    logic [NUM_WAYS-1:0] hitOneHot;
    WayIdx hitWay;
    TagCheckResult checkNext;

    assign opTag = op.addr[ADDR_W-1 -: TAG_W];

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hitOneHot[w] = valids[w] && (tags[w] == opTag);
        end
    end

    // one-hot to index
    // the lowest way wins if the same line ever sits in two ways
    always_comb begin
        hitWay = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (hitOneHot[w]) begin
                hitWay = WayIdx'(w);
            end
        end
    end

    always_comb begin
        checkNext.op = op;
        checkNext.hit = |hitOneHot;
        checkNext.hitWay = hitWay;
        // address bits 3 and 2 pick the word
        checkNext.loadWord = line[hitWay][op.addr[OFFSET_W-1:2]];
        checkNext.victimValid = valids[victimWay];
        checkNext.victimTag = tags[victimWay];
    end

    always_ff @(posedge clk) begin
        result <= checkNext;
        if (rst) begin
            result.op.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/lsuTop.sv
// load/store unit top level connecting issue, cache arrays, tag check and completion
`timescale 1ns/10ps
`default_nettype none

module lsuTop (
    input wire clk,
    input wire rst,
    input wire lsuPkg::LoadReq loadReq,
    input wire lsuPkg::StoreReq storeReq,
    input wire lsuPkg::CacheFill fill,
    input wire missReady,
    output logic loadStall,
    output logic storeStall,
    output lsuPkg::LoadResult loadResult,
    output lsuPkg::LoadAck loadAck,
    output lsuPkg::StoreAck storeAck,
    output lsuPkg::CacheMiss miss
);
    import lsuPkg::*;

    SetIdx readIndex;
    MemOp issuedOp;
    WayTags readTags;
    logic [NUM_WAYS-1:0] readValids;
    WayLines readLines;
    TagCheckResult checkedOp;
    WayIdx victimWay;

    // store write port from completion back to the arrays
    logic storeWrite;
    WayIdx storeWay;
    logic [ADDR_W-1:0] storeAddr;
    Word storeData;
    logic [3:0] storeMask;

    lsuIssue issueStage (
        .clk(clk),
        .rst(rst),
        .loadReq(loadReq),
        .storeReq(storeReq),
        .fillValid(fill.valid),
        .loadStall(loadStall),
        .storeStall(storeStall),
        .readIndex(readIndex),
        .issued(issuedOp)
    );

    cacheArrays arrays (
        .clk(clk),
        .rst(rst),
        .readIndex(readIndex),
        .tagsOut(readTags),
        .validsOut(readValids),
        .lineOut(readLines),
        .fill(fill),
        .storeWrite(storeWrite),
        .storeWay(storeWay),
        .storeAddr(storeAddr),
        .storeData(storeData),
        .storeMask(storeMask)
    );

    lsuTagCheck tagCheck (
        .clk(clk),
        .rst(rst),
        .op(issuedOp),
        .tags(readTags),
        .valids(readValids),
        .line(readLines),
        .victimWay(victimWay),
        .result(checkedOp)
    );

    lsuComplete completeStage (
        .clk(clk),
        .rst(rst),
        .checked(checkedOp),
        .fillValid(fill.valid),
        .missReady(missReady),
        .loadResult(loadResult),
        .loadAck(loadAck),
        .storeAck(storeAck),
        .miss(miss),
        .storeWrite(storeWrite),
        .storeWay(storeWay),
        .storeAddr(storeAddr),
        .storeData(storeData),
        .storeMask(storeMask),
        .victimWay(victimWay)
    );

endmodule

`default_nettype wire

//--- verification/lsuTop_tb.sv
// testbench for lsuTop with random stimulus, reference cache model, refill agent and checks
`timescale 1ns/10ps
`default_nettype none

module lsuTop_tb;
    import lsuPkg::*;

    localparam int NUM_OPS = 1500;
    // four cycles per operation covers the two-cycle load stall behind each store
    localparam int CYCLE_LIMIT = 4 * NUM_OPS + 100;
    localparam int FILL_DELAY = 3;

    logic clk;
    logic rst;
    LoadReq loadReq;
    StoreReq storeReq;
    CacheFill fill;
    logic missReady;
    logic loadStall;
    logic storeStall;
    LoadResult loadResult;
    LoadAck loadAck;
    StoreAck storeAck;
    CacheMiss miss;

    // reference model state
    logic mValid [NUM_SETS][NUM_WAYS];
    Tag mTag [NUM_SETS][NUM_WAYS];
    Word mData [NUM_SETS][NUM_WAYS][WORDS_PER_LINE];
    Word backing [logic [31:0]];
    WayIdx victimCount;

    // ops in flight by acceptance cycle modulo 4 with the set as read at acceptance
    MemOp pipeOp [4];
    logic snapValid [4][NUM_WAYS];
    Tag snapTag [4][NUM_WAYS];
    Word snapWord [4][NUM_WAYS];

    logic [31:0] fillAddrQ [$];
    WayIdx fillWayQ [$];
    int fillDueQ [$];
    logic [31:0] replayQ [$];

    logic [31:0] rngState;
    int cycle;
    int accepted;
    int errorCount;
    logic loadTaken;
    logic storeTaken;
    SeqId nextId;

    int cur;
    int s1;
    int s2;
    MemOp op2;
    logic hit;
    WayIdx hitWay;
    logic expLoadStall;
    SetIdx opSet;
    logic [1:0] opWord;
    LineData fillLine;
    logic [31:0] newAddr;

    lsuTop uut (
        .clk(clk),
        .rst(rst),
        .loadReq(loadReq),
        .storeReq(storeReq),
        .fill(fill),
        .missReady(missReady),
        .loadStall(loadStall),
        .storeStall(storeStall),
        .loadResult(loadResult),
        .loadAck(loadAck),
        .storeAck(storeAck),
        .miss(miss)
    );

    always #4 clk = ~clk;

    function automatic logic [15:0] nextRand();
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return rngState[30:15];
    endfunction

    // six lines with three in set 3 and three in set 9
    function automatic logic [31:0] lineAddr(input int k);
        return {24'(24'h000100 + k), (k % 2 == 1) ? 4'd9 : 4'd3, 4'h0};
    endfunction

    function automatic logic [31:0] randomAddr();
        int k;
        logic [31:0] w;
        k = int'(nextRand() % 16'd6);
        w = 32'(nextRand() % 16'd4);
        return lineAddr(k) | (w << 2);
    endfunction

    // initial memory contents differ at every word address
    function automatic Word readBacking(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (backing.exists(a)) begin
            return backing[a];
        end
        return a ^ {a[7:0], a[31:8]} ^ 32'h5A5A0F0F;
    endfunction

    task automatic checkField(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            errorCount++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        loadReq = '0;
        storeReq = '0;
        fill = '0;
        missReady = 1'b0;
        rngState = 32'd88;
        cycle = 0;
        accepted = 0;
        errorCount = 0;
        loadTaken = 1'b0;
        storeTaken = 1'b0;
        nextId = '0;
        victimCount = '0;
        for (int i = 0; i < 4; i++) begin
            pipeOp[i] = '0;
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                mValid[s][w] = 1'b0;
            end
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        wait (accepted >= NUM_OPS);
        repeat (20) @(posedge clk);
        $display("%0d operations in %0d cycles, %0d errors", accepted, cycle, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // stimulus and refill agent
    always @(posedge clk) begin
        if (!rst) begin
            if (fillDueQ.size() > 0 && fillDueQ[0] <= cycle) begin
                for (int i = 0; i < WORDS_PER_LINE; i++) begin
                    fillLine[i] = readBacking(fillAddrQ[0] | 32'(i * 4));
                end
                fill.valid <= 1'b1;
                fill.addr <= fillAddrQ[0];
                fill.line <= fillLine;
                fill.way <= fillWayQ[0];
                void'(fillAddrQ.pop_front());
                void'(fillWayQ.pop_front());
                void'(fillDueQ.pop_front());
            end else begin
                fill <= '0;
            end
            missReady <= (nextRand() % 16'd4) != 16'd0;
            if (!loadReq.valid || loadTaken) begin
                if (accepted < NUM_OPS && nextRand() % 16'd5 < 16'd2) begin
                    // replay nacked loads first
                    newAddr = (replayQ.size() > 0) ? replayQ.pop_front() : randomAddr();
                    loadReq.valid <= 1'b1;
                    loadReq.addr <= newAddr;
                    loadReq.id <= nextId;
                    nextId = nextId + 6'd1;
                end else begin
                    loadReq <= '0;
                end
            end
            if (!storeReq.valid || storeTaken) begin
                if (accepted < NUM_OPS && nextRand() % 16'd5 < 16'd2) begin
                    storeReq.valid <= 1'b1;
                    storeReq.addr <= randomAddr();
                    storeReq.data <= {nextRand(), nextRand()};
                    storeReq.wmask <= 4'(nextRand());
                    storeReq.id <= nextId;
                    nextId = nextId + 6'd1;
                end else begin
                    storeReq <= '0;
                end
            end
        end
    end

    // model and checks sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        if (!rst) begin
            cycle++;
            cur = cycle % 4;
            s1 = (cycle + 3) % 4;
            s2 = (cycle + 2) % 4;
            op2 = pipeOp[s2];
            hit = 1'b0;
            hitWay = '0;
            for (int w = NUM_WAYS - 1; w >= 0; w--) begin
                if (snapValid[s2][w] && snapTag[s2][w] == op2.addr[ADDR_W-1 -: TAG_W]) begin
                    hit = 1'b1;
                    hitWay = WayIdx'(w);
                end
            end

            checkField("loadResult.valid", 64'(loadResult.valid),
                64'(op2.valid && !op2.isStore && hit));
            if (loadResult.valid && op2.valid) begin
                checkField("loadResult.id", 64'(loadResult.id), 64'(op2.id));
                checkField("loadResult.data", 64'(loadResult.data), 64'(snapWord[s2][hitWay]));
            end
            checkField("loadAck.valid", 64'(loadAck.valid),
                64'(op2.valid && !op2.isStore && !hit));
            if (op2.valid && !op2.isStore && !hit) begin
                checkField("loadAck.id", 64'(loadAck.id), 64'(op2.id));
                checkField("loadAck.addr", 64'(loadAck.addr), 64'(op2.addr));
                replayQ.push_back(op2.addr);
            end
            checkField("storeAck.valid", 64'(storeAck.valid), 64'(op2.valid && op2.isStore));
            if (storeAck.valid && op2.valid) begin
                checkField("storeAck.id", 64'(storeAck.id), 64'(op2.id));
                checkField("storeAck.fail", 64'(storeAck.fail), 64'(!hit || fill.valid));
            end

            checkField("miss.valid", 64'(miss.valid), 64'(op2.valid && !hit));
            if (op2.valid && !hit) begin
                checkField("miss.way", 64'(miss.way), 64'(victimCount));
                checkField("miss.missAddr", 64'(miss.missAddr), 64'(op2.addr));
                checkField("miss.mtype", 64'(miss.mtype),
                    64'(snapValid[s2][victimCount] ? missRegular : missNoEvict));
                if (snapValid[s2][victimCount]) begin
                    checkField("miss.evictAddr", 64'(miss.evictAddr),
                        64'({snapTag[s2][victimCount], op2.addr[OFFSET_W +: INDEX_W], 4'h0}));
                end
                // the refill agent takes the miss only while missReady is high
                if (missReady) begin
                    fillAddrQ.push_back({op2.addr[ADDR_W-1:OFFSET_W], 4'h0});
                    fillWayQ.push_back(victimCount);
                    fillDueQ.push_back(cycle + FILL_DELAY);
                    victimCount = victimCount + 2'd1;
                end
            end

            // store hit merges into the current line and the backing word
            if (op2.valid && op2.isStore && hit && !fill.valid) begin
                opSet = op2.addr[OFFSET_W +: INDEX_W];
                opWord = op2.addr[3:2];
                for (int b = 0; b < 4; b++) begin
                    if (op2.wmask[b]) begin
                        mData[opSet][hitWay][opWord][8*b +: 8] = op2.data[8*b +: 8];
                    end
                end
                backing[{op2.addr[31:2], 2'b00}] = mData[opSet][hitWay][opWord];
            end

            expLoadStall = fill.valid || (pipeOp[s1].valid && pipeOp[s1].isStore)
                || (op2.valid && op2.isStore);
            checkField("loadStall", 64'(loadStall), 64'(expLoadStall));
            checkField("storeStall", 64'(storeStall), 64'(fill.valid || loadReq.valid));

            loadTaken = loadReq.valid && !expLoadStall;
            storeTaken = storeReq.valid && !fill.valid && !loadReq.valid;
            pipeOp[cur] = '0;
            if (loadTaken) begin
                pipeOp[cur].valid = 1'b1;
                pipeOp[cur].addr = loadReq.addr;
                pipeOp[cur].id = loadReq.id;
            end else if (storeTaken) begin
                pipeOp[cur].valid = 1'b1;
                pipeOp[cur].isStore = 1'b1;
                pipeOp[cur].addr = storeReq.addr;
                pipeOp[cur].data = storeReq.data;
                pipeOp[cur].wmask = storeReq.wmask;
                pipeOp[cur].id = storeReq.id;
            end
            if (pipeOp[cur].valid) begin
                accepted++;
                opSet = pipeOp[cur].addr[OFFSET_W +: INDEX_W];
                for (int w = 0; w < NUM_WAYS; w++) begin
                    snapValid[cur][w] = mValid[opSet][w];
                    snapTag[cur][w] = mTag[opSet][w];
                    snapWord[cur][w] = mData[opSet][w][pipeOp[cur].addr[3:2]];
                end
            end

            // fills land after this cycle's array read
            if (fill.valid) begin
                opSet = fill.addr[OFFSET_W +: INDEX_W];
                mValid[opSet][fill.way] = 1'b1;
                mTag[opSet][fill.way] = fill.addr[ADDR_W-1 -: TAG_W];
                for (int i = 0; i < WORDS_PER_LINE; i++) begin
                    mData[opSet][fill.way][i] = fill.line[i];
                end
            end

            if (cycle >= CYCLE_LIMIT) begin
                $display("timeout after %0d cycles with %0d of %0d operations accepted, %0d errors",
                    cycle, accepted, NUM_OPS, errorCount);
                $display("Testbench failed");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire
